//--- alConfigPkg.sv
// ####################################################################
// Active list configuration
// Entry count, pointer and PC widths, completion lane count and the
// pointer and occupancy types shared by all active list blocks
// ####################################################################

package alConfigPkg;

    // Number of entries in the list
    localparam int alDepth = 16;

    // Width of one entry pointer
    localparam int alIndexBits = 4;

    // Program counter width
    localparam int pcBits = 32;

    // Execution result write ports
    localparam int completeLanes = 2;

    // Pointer into the circular entry array
    typedef logic [alIndexBits-1:0] AlIndex;

    // Occupancy, one bit wider so a full list is representable
    typedef logic [alIndexBits:0] AlCount;

endpackage : alConfigPkg

//--- alOpPkg.sv
// ####################################################################
// Active list op types
// Execution states, redirect kinds and the packed records that move
// between dispatch, completion, the fault recorder and commit
// ####################################################################

package alOpPkg;

    // Per-entry execution result
    typedef enum logic [1:0] {
        notFinished = 2'd0,
        success     = 2'd1,
        refetchThis = 2'd2,
        refetchNext = 2'd3
    } ExecState;

    // Where fetch restarts after a flushing commit
    typedef enum logic [1:0] {
        redirectThisPc       = 2'd0,
        redirectNextPc       = 2'd1,
        redirectBranchTarget = 2'd2
    } RedirectKind;

    // Payload written at dispatch
    typedef struct packed {
        logic [alConfigPkg::pcBits-1:0] pc;
        logic                           isBranch;
    } AlEntry;

    // One completion lane, target only meaningful for branches
    typedef struct packed {
        logic                           valid;
        alConfigPkg::AlIndex            ptr;
        ExecState                       state;
        logic [alConfigPkg::pcBits-1:0] target;
    } CompleteData;

    // Oldest faulting op seen so far
    typedef struct packed {
        logic                           valid;
        alConfigPkg::AlIndex            ptr;
        logic [alConfigPkg::pcBits-1:0] pc;
        logic [alConfigPkg::pcBits-1:0] target;
        RedirectKind                    kind;
    } FaultRecord;

    typedef struct packed {
        logic                           valid;
        logic [alConfigPkg::pcBits-1:0] pc;
        ExecState                       state;
        logic                           flush;
    } CommitData;

endpackage : alOpPkg

//--- alQueuePointer.sv
// ####################################################################
// Active list queue pointers
// Circular head and tail pointers plus occupancy count, with a flush
// that empties the list in one cycle
// ####################################################################

`timescale 1ns/1ps

module alQueuePointer (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic                pop,
    input  logic                flush,
    output alConfigPkg::AlIndex headPtr,
    output alConfigPkg::AlIndex tailPtr,
    output alConfigPkg::AlCount count
);
    import alConfigPkg::*;

    AlIndex nextHead;
    AlIndex nextTail;

    // Step one entry forward, wrapping at the list size
    function automatic AlIndex wrapInc(input AlIndex ptr);
        if (ptr == AlIndex'(alDepth - 1)) begin
            return '0;
        end
        return ptr + AlIndex'(1);
    endfunction

    always_comb begin
        nextTail = push ? wrapInc(tailPtr) : tailPtr;
        nextHead = pop ? wrapInc(headPtr) : headPtr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            tailPtr <= nextTail;
            if (flush) begin
                // Drop everything younger than the flushing op
                headPtr <= nextTail;
                count   <= '0;
            end else begin
                headPtr <= nextHead;
                count   <= count + AlCount'(push) - AlCount'(pop);
            end
        end
    end

endmodule : alQueuePointer

//--- alEntryStore.sv
// ####################################################################
// Active list entry store
// Payload and execution state arrays with one dispatch write port,
// one write port per completion lane and a head read port
// ####################################################################

`timescale 1ns/1ps

module alEntryStore (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  alConfigPkg::AlIndex  tailPtr,
    input  alOpPkg::AlEntry      dispatchEntry,
    input  alOpPkg::CompleteData complete [alConfigPkg::completeLanes],
    input  alConfigPkg::AlIndex  headPtr,
    output alOpPkg::AlEntry      headEntry,
    output logic                 headDone,
    output alOpPkg::ExecState    headState,
    output alOpPkg::AlEntry      completeEntry [alConfigPkg::completeLanes]
);
    import alConfigPkg::*;
    import alOpPkg::*;

    AlEntry             payload  [alDepth];
    ExecState           stateMem [alDepth];
    logic [alDepth-1:0] doneBits;

    // Payload is written once, at dispatch
    always_ff @(posedge clk) begin
        if (push) begin
            payload[tailPtr] <= dispatchEntry;
        end
    end

    // Results arrive in any order
    always_ff @(posedge clk) begin
        for (int i = 0; i < completeLanes; i++) begin
            if (complete[i].valid) begin
                stateMem[complete[i].ptr] <= complete[i].state;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            doneBits <= '0;
        end else begin
            // A fresh entry starts unfinished
            if (push) begin
                doneBits[tailPtr] <= 1'b0;
            end
            for (int i = 0; i < completeLanes; i++) begin
                if (complete[i].valid) begin
                    doneBits[complete[i].ptr] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        headEntry = payload[headPtr];
        headDone  = doneBits[headPtr];
        headState = stateMem[headPtr];
        // PC and branch flag of each completing op, for the fault recorder
        for (int i = 0; i < completeLanes; i++) begin
            completeEntry[i] = payload[complete[i].ptr];
        end
    end

endmodule : alEntryStore

//--- alFaultRecorder.sv
// ####################################################################
// Active list fault recorder
// Keeps the oldest refetching op seen on the completion lanes, ranked
// by age from the head, and picks where fetch restarts for it
// ####################################################################

`timescale 1ns/1ps

module alFaultRecorder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  alConfigPkg::AlIndex  headPtr,
    input  alOpPkg::CompleteData complete [alConfigPkg::completeLanes],
    input  alOpPkg::AlEntry      completeEntry [alConfigPkg::completeLanes],
    output alOpPkg::FaultRecord  fault
);
    import alConfigPkg::*;
    import alOpPkg::*;

    FaultRecord nextFault;
    AlIndex     oldestAge;
    AlIndex     laneAge   [completeLanes];
    logic       laneFault [completeLanes];

    // Restart point for a refetching op
    function automatic RedirectKind pickKind(input ExecState state, input logic isBranch);
        if (state == refetchThis) begin
            return redirectThisPc;
        end
        if (isBranch) begin
            return redirectBranchTarget;
        end
        return redirectNextPc;
    endfunction

    always_comb begin
        nextFault = fault;
        // Age is distance from the head, smaller is older
        oldestAge = fault.ptr - headPtr;
        for (int i = 0; i < completeLanes; i++) begin
            laneAge[i]   = complete[i].ptr - headPtr;
            laneFault[i] = complete[i].valid &&
                           (complete[i].state inside {refetchThis, refetchNext});
            if (laneFault[i] && (!nextFault.valid || laneAge[i] < oldestAge)) begin
                oldestAge        = laneAge[i];
                nextFault.valid  = 1'b1;
                nextFault.ptr    = complete[i].ptr;
                nextFault.pc     = completeEntry[i].pc;
                nextFault.target = complete[i].target;
                nextFault.kind   = pickKind(complete[i].state, completeEntry[i].isBranch);
            end
        end
    end

    // Flush retires the recorded op, anything younger is gone with it
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fault <= '0;
        end else begin
            fault <= nextFault;
        end
    end

endmodule : alFaultRecorder

//--- alCommitUnit.sv
// ####################################################################
// Active list commit unit
// Resolves the head state, retires the head when it is done and not
// stalled, and raises flush and redirect on a refetching commit
// ####################################################################

`timescale 1ns/1ps

module alCommitUnit (
    input  alConfigPkg::AlCount          count,
    input  alConfigPkg::AlIndex          headPtr,
    input  alOpPkg::AlEntry              headEntry,
    input  logic                         headDone,
    input  alOpPkg::ExecState            headState,
    input  alOpPkg::FaultRecord          fault,
    input  logic                         commitStall,
    output logic                         pop,
    output logic                         flush,
    output alOpPkg::CommitData           commitOut,
    output logic                         redirectValid,
    output logic [alConfigPkg::pcBits-1:0] redirectPc
);
    import alConfigPkg::*;
    import alOpPkg::*;

    logic        faultAtHead;
    logic        isRefetch;
    ExecState    resolvedState;
    RedirectKind kind;

    always_comb begin
        // Recorded fault overrides the stored state at the head
        faultAtHead = fault.valid && (fault.ptr == headPtr);
        if (faultAtHead) begin
            resolvedState = (fault.kind == redirectThisPc) ? refetchThis : refetchNext;
            kind          = fault.kind;
        end else begin
            resolvedState = headState;
            kind          = (headState == refetchThis) ? redirectThisPc : redirectNextPc;
        end

        pop       = headDone && (count != '0) && !commitStall;
        isRefetch = resolvedState inside {refetchThis, refetchNext};
        flush     = pop && isRefetch;

        case (kind)
            redirectThisPc:       redirectPc = headEntry.pc;
            redirectBranchTarget: redirectPc = fault.target;
            default:              redirectPc = headEntry.pc + pcBits'(4);
        endcase
        redirectValid = flush;

        commitOut.valid = pop;
        commitOut.pc    = headEntry.pc;
        commitOut.state = resolvedState;
        commitOut.flush = flush;
    end

endmodule : alCommitUnit

//--- activeList.sv
// ####################################################################
// Active list top
// In-order commit tracker with one dispatch lane, two completion
// lanes and one commit lane around a 16-entry circular queue
// ####################################################################

`timescale 1ns/1ps

module activeList (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           dispatchPush,
    input  alOpPkg::AlEntry                dispatchEntry,
    output logic                           allocatable,
    output alConfigPkg::AlIndex            dispatchPtr,
    input  alOpPkg::CompleteData           complete [alConfigPkg::completeLanes],
    input  logic                           commitStall,
    output alOpPkg::CommitData             commitOut,
    output logic                           redirectValid,
    output logic [alConfigPkg::pcBits-1:0] redirectPc,
    output alOpPkg::FaultRecord            pendingFault,
    output logic                           empty
);
    import alConfigPkg::*;
    import alOpPkg::*;

    AlIndex   headPtr;
    AlIndex   tailPtr;
    AlCount   count;
    AlEntry   headEntry;
    logic     headDone;
    ExecState headState;
    AlEntry   completeEntry [completeLanes];
    logic     pop;
    logic     flush;

    alQueuePointer queuePtr0 (
        .clk     (clk),
        .rst     (rst),
        .push    (dispatchPush),
        .pop     (pop),
        .flush   (flush),
        .headPtr (headPtr),
        .tailPtr (tailPtr),
        .count   (count)
    );

    alEntryStore entryStore0 (
        .clk           (clk),
        .rst           (rst),
        .push          (dispatchPush),
        .tailPtr       (tailPtr),
        .dispatchEntry (dispatchEntry),
        .complete      (complete),
        .headPtr       (headPtr),
        .headEntry     (headEntry),
        .headDone      (headDone),
        .headState     (headState),
        .completeEntry (completeEntry)
    );

    // Record is visible to the core ahead of commit
    alFaultRecorder faultRec0 (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .headPtr       (headPtr),
        .complete      (complete),
        .completeEntry (completeEntry),
        .fault         (pendingFault)
    );

    alCommitUnit commit0 (
        .count         (count),
        .headPtr       (headPtr),
        .headEntry     (headEntry),
        .headDone      (headDone),
        .headState     (headState),
        .fault         (pendingFault),
        .commitStall   (commitStall),
        .pop           (pop),
        .flush         (flush),
        .commitOut     (commitOut),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    always_comb begin
        // New entry lands at the tail
        dispatchPtr = tailPtr;
        allocatable = count < AlCount'(alDepth);
        empty       = count == '0;
    end

endmodule : activeList

//--- activeList_props.sv
// ####################################################################
// Active list properties
// Handshake and commit invariants checked on the top level
// ####################################################################

`timescale 1ns/1ps

module activeList_props (
    input logic               clk,
    input logic               rst,
    input logic               dispatchPush,
    input logic               allocatable,
    input alOpPkg::CommitData commitOut,
    input logic               redirectValid,
    input logic               empty
);

    // Number of assertion failures so far
    int failCount = 0;

    // Push only into a free slot
    pushNeedsRoom: assert property (@(posedge clk) disable iff (rst)
        dispatchPush |-> allocatable)
        else begin
            failCount++;
            $error("dispatch pushed while the list was full");
        end

    // Redirect travels with a flushing commit, which empties the list
    redirectOnFlush: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> commitOut.flush ##1 empty)
        else begin
            failCount++;
            $error("redirect raised without a flushing commit that empties the list");
        end

    emptyNoCommit: assert property (@(posedge clk) disable iff (rst)
        !(empty && commitOut.valid))
        else begin
            failCount++;
            $error("commit reported from an empty list");
        end

endmodule : activeList_props

bind activeList activeList_props props0 (
    .clk           (clk),
    .rst           (rst),
    .dispatchPush  (dispatchPush),
    .allocatable   (allocatable),
    .commitOut     (commitOut),
    .redirectValid (redirectValid),
    .empty         (empty)
);

//--- activeListTb.sv
// ####################################################################
// Active list testbench
// Replays dispatch, completion and stall commands from a data file and
// checks commits, redirects, occupancy and the pending fault record
// ####################################################################

`timescale 1ns/1ps

module activeListTb;
    import alConfigPkg::*;
    import alOpPkg::*;

    logic              clk;
    logic              rst;
    logic              dispatchPush;
    AlEntry            dispatchEntry;
    logic              allocatable;
    AlIndex            dispatchPtr;
    CompleteData       complete [completeLanes];
    logic              commitStall;
    CommitData         commitOut;
    logic              redirectValid;
    logic [pcBits-1:0] redirectPc;
    FaultRecord        pendingFault;
    logic              empty;

    // Completions collected until the next non-completion command
    CompleteData       staged [completeLanes];
    CommitData         commitQ [$];
    logic [pcBits-1:0] redirectQ [$];
    logic [7:0]        lfsr;
    string             testName;
    int                testErrors;
    int                totalErrors;
    int                testsRun;
    int                testsFailed;

    // Model of the tail and of the PC dispatched into each entry
    int                expTail;
    logic [pcBits-1:0] expPc [alDepth];

    activeList dut0 (
        .clk           (clk),
        .rst           (rst),
        .dispatchPush  (dispatchPush),
        .dispatchEntry (dispatchEntry),
        .allocatable   (allocatable),
        .dispatchPtr   (dispatchPtr),
        .complete      (complete),
        .commitStall   (commitStall),
        .commitOut     (commitOut),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .pendingFault  (pendingFault),
        .empty         (empty)
    );

    always #2 clk = ~clk;

    // Every commit is logged, redirect PC is zero when no redirect
    always @(negedge clk) begin
        if (!rst && commitOut.valid) begin
            commitQ.push_back(commitOut);
            redirectQ.push_back(redirectValid ? redirectPc : '0);
        end
    end

    // Entries fill from 0 in dispatch order and wrap after the last one
    always @(negedge clk) begin
        if (!rst && dispatchPush) begin
            checkValue("dispatch ptr", 32'(expTail), 32'(dispatchPtr));
            expPc[expTail] = dispatchEntry.pc;
            expTail        = (expTail + 1) % alDepth;
        end
    end

    function automatic logic [7:0] lfsrNext(input logic [7:0] state);
        return state[0] ? ((state >> 1) ^ 8'hB8) : (state >> 1);
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    // Zero to three idle cycles, one LFSR step per bit
    task automatic idleGap();
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            gap = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsrNext(lfsr);
        end
        repeat (gap) @(posedge clk);
    endtask

    // One push at a time, each only once allocatable is seen high
    task automatic dispatchOps(input logic [31:0] pc, input logic isBranch, input int n);
        int waited;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            @(negedge clk);
            while (!allocatable && waited < 50) begin
                @(negedge clk);
                waited++;
            end
            if (!allocatable) begin
                $display("%s: no free entry for pc %h within 50 cycles",
                         testName, pc + 32'(4 * k));
                testErrors++;
                break;
            end
            @(posedge clk);
            dispatchPush           <= 1'b1;
            dispatchEntry.pc       <= pc + 32'(4 * k);
            dispatchEntry.isBranch <= isBranch;
            @(posedge clk);
            dispatchPush <= 1'b0;
        end
    endtask

    // Drive all staged lanes in the same cycle
    task automatic fireStaged();
        logic any;
        any = 1'b0;
        for (int i = 0; i < completeLanes; i++) begin
            any = any | staged[i].valid;
        end
        if (any) begin
            @(posedge clk);
            for (int i = 0; i < completeLanes; i++) begin
                complete[i] <= staged[i];
            end
            @(posedge clk);
            for (int i = 0; i < completeLanes; i++) begin
                complete[i] <= '0;
                staged[i] = '0;
            end
        end
    endtask

    task automatic stageCompletion(input int lane, input logic [31:0] ptr,
                                   input logic [31:0] state, input logic [31:0] target);
        if (staged[lane].valid) begin
            fireStaged();
        end
        staged[lane].valid  = 1'b1;
        staged[lane].ptr    = AlIndex'(ptr);
        staged[lane].state  = ExecState'(state[1:0]);
        staged[lane].target = target;
    endtask

    task automatic expectCommit(input logic [31:0] pc, input logic [31:0] state,
                                input logic [31:0] flush, input logic [31:0] target);
        CommitData         got;
        logic [pcBits-1:0] gotRedirect;
        int                waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (commitQ.size() == 0 && waited < 50);
        if (commitQ.size() == 0) begin
            $display("%s: no commit of pc %h arrived within 50 cycles", testName, pc);
            testErrors++;
        end else begin
            got         = commitQ.pop_front();
            gotRedirect = redirectQ.pop_front();
            checkValue("commit pc", pc, got.pc);
            checkValue("commit state", state, 32'(got.state));
            checkValue("commit flush", flush, 32'(got.flush));
            checkValue("redirect pc", target, gotRedirect);
        end
    endtask

    task automatic endTest();
        if (testName != "") begin
            // Anything left here committed without a matching line
            if (commitQ.size() != 0) begin
                $display("%s: %0d commits that were not expected, first at pc %h",
                         testName, commitQ.size(), commitQ[0].pc);
                testErrors++;
                commitQ.delete();
                redirectQ.delete();
            end
            testsRun++;
            totalErrors += testErrors;
            if (testErrors != 0) begin
                testsFailed++;
            end
            $display("[%s] %s, %0d errors", testName, testErrors == 0 ? "ok" : "bad",
                     testErrors);
        end
    endtask

    task automatic startTest(input string name);
        endTest();
        testName   = name;
        testErrors = 0;
    endtask

    task automatic runCommand(input string line);
        logic [7:0]  op;
        logic [31:0] a, b, c, d;
        op = line.getc(0);
        a  = '0;
        b  = '0;
        c  = '0;
        d  = '0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
        if (op != "C") begin
            fireStaged();
        end
        case (op)
            "T": startTest(line.substr(2, line.len() - 2));
            "D": dispatchOps(a, b[0], int'(c));
            "C": stageCompletion(int'(a), b, c, d);
            "E": expectCommit(a, b, c, d);
            "S": begin
                @(posedge clk);
                commitStall <= a[0];
            end
            "N": begin
                @(negedge clk);
                checkValue("count", a, 32'(dut0.count));
                checkValue("empty", 32'(a == 32'd0), 32'(empty));
            end
            "A": begin
                @(negedge clk);
                checkValue("allocatable", a, 32'(allocatable));
            end
            "F": begin
                @(negedge clk);
                checkValue("fault valid", 32'd1, 32'(pendingFault.valid));
                checkValue("fault ptr", a, 32'(pendingFault.ptr));
                checkValue("fault pc", expPc[a[alIndexBits-1:0]], pendingFault.pc);
            end
            default: begin
                $display("%s: unknown command in the data file: %s", testName, line);
                testErrors++;
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        clk           = 1'b0;
        rst           = 1'b1;
        dispatchPush  = 1'b0;
        dispatchEntry = '0;
        commitStall   = 1'b0;
        for (int i = 0; i < completeLanes; i++) begin
            complete[i] = '0;
            staged[i]   = '0;
        end
        lfsr        = 8'd21;
        testName    = "";
        testErrors  = 0;
        totalErrors = 0;
        testsRun    = 0;
        testsFailed = 0;
        expTail     = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("activeList_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open activeList_testdata.txt");
            totalErrors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                idleGap();
                runCommand(line);
            end
            $fclose(fd);
        end
        fireStaged();
        endTest();

        if (dut0.props0.failCount != 0) begin
            $display("%0d assertion failures in the bound checks", dut0.props0.failCount);
            totalErrors += dut0.props0.failCount;
        end

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : activeListTb

//--- activeList_testdata.txt
# T name | D pc isBranch n | C lane ptr state target | S stall | A allocatable | F faultPtr
# E pc state flush redirectPc | N count | all hex, state 1 success 2 refetchThis 3 refetchNext
T reset
A 1
N 0
D 1000 0 3
N 3
T order
C 0 2 1 0
C 0 0 1 0
C 1 1 1 0
E 1000 1 0 0
E 1004 1 0 0
E 1008 1 0 0
N 0
T full
D 2000 0 10
A 0
C 0 3 1 0
E 2000 1 0 0
A 1
T stall
S 1
C 0 4 1 0
N f
S 0
E 2004 1 0 0
T fault
C 0 8 3 0
C 1 6 2 0
F 6
C 0 5 1 0
E 2008 1 0 0
E 200c 2 1 200c
N 0
T redirect
D 3000 0 1
C 0 3 3 0
E 3000 3 1 3004
D 3100 1 1
C 1 4 3 4000
E 3100 3 1 4000
N 0

//--- flist.f
alConfigPkg.sv
alOpPkg.sv
alQueuePointer.sv
alEntryStore.sv
alFaultRecorder.sv
alCommitUnit.sv
activeList.sv
activeList_props.sv
activeListTb.sv

//--- Makefile
# Verilator build, run and lint for the active list

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module activeListTb

run: build
	./obj_dir/VactiveListTb > sim.log 2>&1 || echo "test failed" >> sim.log
	cat sim.log
	! grep -q "test failed" sim.log

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module activeList

clean:
	rm -rf obj_dir sim.log
